/* design/scan_pkg.sv */
package scan_pkg;

   // Longest literal pattern supported
   // also the width of one stream memory word
   localparam int MAX_PAT_LEN = 11;

   // Width of a pattern parameter, one byte per position
   localparam int PAT_W = MAX_PAT_LEN * 8;

   // Stream id width and the resulting stream count
   localparam int STREAM_W = 6;
   localparam int NUM_STREAMS = 1 << STREAM_W;

   // Packet counts wrap, no saturation
   localparam int COUNT_W = 16;

   // Categories scanned side by side at the top level
   localparam int NUM_CAT = 2;

   typedef logic [7:0] byte_t;
   typedef logic [STREAM_W-1:0] stream_id_t;
   typedef logic [MAX_PAT_LEN-1:0] match_state_t;
   typedef logic [COUNT_W-1:0] count_t;

   // Per-cycle inputs shared by every category
   typedef struct packed {
      byte_t      char_in;
      logic       char_vld;
      logic       load_state;
      logic       new_stream;
      logic       eop;
      stream_id_t stream_id;
   } scan_in_t;

endpackage

/* design/prefix_matcher.sv */
module prefix_matcher import scan_pkg::*; #(
   // Literal pattern, first byte in the highest used byte lane
   parameter logic [PAT_W-1:0] PATTERN = "yahoo",
   // Number of used bytes in PATTERN, 1 to MAX_PAT_LEN
   parameter int PAT_LEN = 5
) (
   input  logic         clk,
   input  logic         rst_n,
   input  byte_t        char_in,
   input  logic         char_vld,
   input  logic         load,
   input  match_state_t load_state,
   output match_state_t state,
   output logic         accept
);

   // Ones on the bit positions that belong to the pattern
   localparam match_state_t LEN_MASK = match_state_t'((1 << PAT_LEN) - 1);

   // Bit k set when pattern byte k equals the current character
   match_state_t match_mask;

   // State after consuming char_in
   match_state_t next_state;

   // One comparator per pattern position
   // positions past the pattern end never match
   genvar k;
   generate
      for (k = 0; k < MAX_PAT_LEN; k++)
      begin : g_cmp
         if (k < PAT_LEN)
         begin : g_used
            // String literals are right aligned, so byte k sits
            // PAT_LEN-1-k lanes above bit 0
            assign match_mask[k] = (PATTERN[(PAT_LEN-1-k)*8 +: 8] == char_in);
         end
         else
         begin : g_unused
            assign match_mask[k] = 1'b0;
         end
      end
   endgenerate

   // Shift-and step
   // every live prefix grows by one, and a fresh prefix starts at bit 0,
   // then only prefixes whose next byte matched survive
   always_comb
   begin
      next_state = {state[MAX_PAT_LEN-2:0], 1'b1} & match_mask & LEN_MASK;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state  <= '0;
         accept <= 1'b0;
      end
      else if (load)
      begin
         // Restore wins over any byte in the same cycle
         state  <= load_state & LEN_MASK;
         accept <= 1'b0;
      end
      else if (char_vld)
      begin
         state  <= next_state;
         // Full pattern seen when the top prefix bit survives
         accept <= next_state[PAT_LEN-1];
      end
      else
      begin
         // Idle cycle, state holds
         accept <= 1'b0;
      end
   end

endmodule

/* design/category_counter.sv */
module category_counter import scan_pkg::*; #(
   parameter logic [PAT_W-1:0] PATTERN = "yahoo",
   parameter int PAT_LEN = 5
) (
   input  logic     clk,
   input  logic     rst_n,
   input  scan_in_t scan_in,
   input  logic     enable,
   output count_t   count,
   output logic     fired
);

   // Saved matcher state, one word per stream
   // undefined until the first enabled eop of that stream
   match_state_t state_mem [NUM_STREAMS];

   // Restore value and its strobe toward the matcher
   match_state_t restore_state;
   logic         restore_vld;

   // Matcher outputs
   match_state_t cur_state;
   logic         accept;

   // Enabled end of packet commits this category
   logic         commit;

   assign commit = scan_in.eop & enable;

   // Restore path
   // new stream starts from empty state, otherwise resume the saved word
   always_ff @(posedge clk)
   begin
      if (scan_in.load_state)
      begin
         if (scan_in.new_stream)
         begin
            restore_state <= '0;
         end
         else
         begin
            restore_state <= state_mem[scan_in.stream_id];
         end
      end
   end

   // Load strobe lands on the matcher one edge after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         restore_vld <= 1'b0;
      end
      else
      begin
         restore_vld <= scan_in.load_state;
      end
   end

   // Save path, only when this category is enabled for the packet
   always_ff @(posedge clk)
   begin
      if (commit)
      begin
         state_mem[scan_in.stream_id] <= cur_state;
      end
   end

   // Per-packet fired flag and packet count
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
         fired <= 1'b0;
      end
      else
      begin
         // Start of packet forgets the previous result
         if (scan_in.load_state)
         begin
            fired <= 1'b0;
         end
         // Any number of hits in a packet counts once
         if (accept)
         begin
            fired <= 1'b1;
         end
         if (scan_in.eop)
         begin
            if (enable)
            begin
               count <= count + count_t'(fired);
            end
            else
            begin
               // Disabled packet leaves no trace, saved state untouched
               fired <= 1'b0;
            end
         end
      end
   end

   prefix_matcher #(
      .PATTERN (PATTERN),
      .PAT_LEN (PAT_LEN)
   ) u_matcher (
      .clk        (clk),
      .rst_n      (rst_n),
      .char_in    (scan_in.char_in),
      .char_vld   (scan_in.char_vld),
      .load       (restore_vld),
      .load_state (restore_state),
      .state      (cur_state),
      .accept     (accept)
   );

endmodule

/* design/packet_scanner.sv */
module packet_scanner import scan_pkg::*; #(
   // Category A pattern and its length
   parameter logic [PAT_W-1:0] PATTERN_A = "yahoo",
   parameter int PAT_LEN_A = 5,
   // Category B pattern and its length
   parameter logic [PAT_W-1:0] PATTERN_B = "mail",
   parameter int PAT_LEN_B = 4
) (
   input  logic                 clk,
   input  logic                 rst_n,
   // Shared per-byte inputs, broadcast to every category
   input  scan_in_t             scan_in,
   // Per-category enable, sampled at eop
   input  logic [NUM_CAT-1:0]   enable,
   // Per-category packet counts
   output count_t [NUM_CAT-1:0] counts,
   // Per-category fired flags for the current packet
   output logic [NUM_CAT-1:0]   fired
);

   // No registers at this level
   // byte to fired latency is set entirely inside the counters

   // Category A, lane 0 of enable, counts and fired
   category_counter #(
      .PATTERN (PATTERN_A),
      .PAT_LEN (PAT_LEN_A)
   ) u_cat_a (
      .clk     (clk),
      .rst_n   (rst_n),
      .scan_in (scan_in),
      .enable  (enable[0]),
      .count   (counts[0]),
      .fired   (fired[0])
   );

   // Category B, lane 1
   // keeps its own stream memory, so the two categories
   // resume independently even on the same stream id
   category_counter #(
      .PATTERN (PATTERN_B),
      .PAT_LEN (PAT_LEN_B)
   ) u_cat_b (
      .clk     (clk),
      .rst_n   (rst_n),
      .scan_in (scan_in),
      .enable  (enable[1]),
      .count   (counts[1]),
      .fired   (fired[1])
   );

endmodule

/* verif/scan_checker.sv */
module scan_checker import scan_pkg::*; #(
   parameter logic [PAT_W-1:0] PATTERN_A = PAT_W'("yahoo"),
   parameter int PAT_LEN_A = 5,
   parameter logic [PAT_W-1:0] PATTERN_B = PAT_W'("mail"),
   parameter int PAT_LEN_B = 4,
   // Cycles allowed for the whole run, reset included
   parameter int CYCLE_LIMIT = 10000
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  scan_in_t             scan_in,
   input  logic [NUM_CAT-1:0]   enable,
   input  count_t [NUM_CAT-1:0] counts,
   input  logic [NUM_CAT-1:0]   fired,
   output int                   error_count,
   output bit                   timed_out
);

   // Model of each category, live state and saved state per stream
   match_state_t m_state [NUM_CAT];
   match_state_t m_saved [NUM_CAT][NUM_STREAMS];
   logic         m_fired [NUM_CAT];
   count_t       m_count [NUM_CAT];

   // High in the cycle after an eop edge
   logic         check_due;
   int           cycle_count;

   function automatic logic [PAT_W-1:0] pat_of(input int c);
      return (c == 0) ? PATTERN_A : PATTERN_B;
   endfunction

   function automatic int len_of(input int c);
      return (c == 0) ? PAT_LEN_A : PAT_LEN_B;
   endfunction

   // One shift-and step on a literal pattern
   // prefix k+1 matches when prefix k matched before and byte k equals ch
   function automatic match_state_t shift_and_step(input logic [PAT_W-1:0] pat, input int len,
                                                   input match_state_t st, input byte_t ch,
                                                   output logic hit);
      match_state_t nxt;
      logic         prev;
      nxt  = '0;
      // Empty prefix always matches
      prev = 1'b1;
      for (int k = 0; k < len; k++)
      begin
         // First pattern character sits in the highest used byte of the literal
         nxt[k] = prev && (pat[(len-1-k)*8 +: 8] == ch);
         prev   = st[k];
      end
      hit = nxt[len-1];
      return nxt;
   endfunction

   // Reference model, follows the restore and save rules per packet
   always @(posedge clk)
   begin : model_update
      logic hit;
      if (!rst_n)
      begin
         for (int c = 0; c < NUM_CAT; c++)
         begin
            m_state[c] = '0;
            m_fired[c] = 1'b0;
            m_count[c] = '0;
         end
         check_due = 1'b0;
      end
      else
      begin
         for (int c = 0; c < NUM_CAT; c++)
         begin
            if (scan_in.load_state)
            begin
               m_state[c] = scan_in.new_stream ? '0 : m_saved[c][scan_in.stream_id];
               m_fired[c] = 1'b0;
            end
            if (scan_in.char_vld)
            begin
               m_state[c] = shift_and_step(pat_of(c), len_of(c), m_state[c], scan_in.char_in,
                                           hit);
               if (hit)
               begin
                  m_fired[c] = 1'b1;
               end
            end
            if (scan_in.eop)
            begin
               if (enable[c])
               begin
                  m_count[c]                    = m_count[c] + count_t'(m_fired[c]);
                  m_saved[c][scan_in.stream_id] = m_state[c];
               end
               else
               begin
                  m_fired[c] = 1'b0;
               end
            end
         end
         check_due = scan_in.eop;
      end
   end

   // Outputs settle one cycle after eop, compared mid cycle
   always @(negedge clk)
   begin
      if (rst_n && check_due)
      begin
         for (int c = 0; c < NUM_CAT; c++)
         begin
            if (counts[c] !== m_count[c])
            begin
               error_count++;
               $display("mismatch counts[%0d]: got %h expected %h", c, counts[c], m_count[c]);
            end
            if (fired[c] !== m_fired[c])
            begin
               error_count++;
               $display("mismatch fired[%0d]: got %h expected %h", c, fired[c], m_fired[c]);
            end
         end
      end
   end

   // Run length guard
   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == CYCLE_LIMIT)
      begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         timed_out <= 1'b1;
      end
   end

endmodule

/* verif/scan_assert.sv */
module scan_assert import scan_pkg::*; (
   input logic               clk,
   input logic               rst_n,
   input scan_in_t           scan_in,
   input logic [NUM_CAT-1:0] fired
);

   // Failure tallies, one per property
   int excl_fails;
   int load_gap_fails;
   int eop_gap_fails;
   int fired_clear_fails;
   int fail_count;

   assign fail_count = excl_fails + load_gap_fails + eop_gap_fails + fired_clear_fails;

   // Start and end of packet never share a cycle
   a_load_eop_excl : assert property (@(posedge clk) disable iff (!rst_n)
      !(scan_in.eop && scan_in.load_state))
   else
   begin
      excl_fails++;
      $error("eop and load_state high in the same cycle");
   end

   // Matcher loads one edge after load_state, no byte may meet it
   a_load_gap : assert property (@(posedge clk) disable iff (!rst_n)
      scan_in.load_state |=> !scan_in.char_vld)
   else
   begin
      load_gap_fails++;
      $error("char_vld high right after load_state");
   end

   // Last accept must reach fired before eop commits it
   a_eop_gap : assert property (@(posedge clk) disable iff (!rst_n)
      scan_in.eop |-> (!$past(scan_in.char_vld, 1) && !$past(scan_in.char_vld, 2)))
   else
   begin
      eop_gap_fails++;
      $error("char_vld high within two cycles before eop");
   end

   a_fired_clear : assert property (@(posedge clk) disable iff (!rst_n)
      scan_in.load_state |=> (fired == '0))
   else
   begin
      fired_clear_fails++;
      $error("fired not cleared after load_state");
   end

endmodule

bind packet_scanner scan_assert u_assert (
   .clk     (clk),
   .rst_n   (rst_n),
   .scan_in (scan_in),
   .fired   (fired)
);

/* verif/tb_top.sv */
module tb_top import scan_pkg::*; ();

   // Patterns under test widened to the full pattern parameter
   localparam logic [PAT_W-1:0] PAT_A = PAT_W'("yahoo");
   localparam int PAT_LEN_A = 5;
   localparam logic [PAT_W-1:0] PAT_B = PAT_W'("mail");
   localparam int PAT_LEN_B = 4;

   localparam int RESET_CYCLES = 8;
   localparam int NUM_DIRECTED = 12;
   localparam int NUM_RANDOM = 200;
   localparam int NUM_PACKETS = NUM_DIRECTED + NUM_RANDOM;
   // Longest packet with gaps stays well below 40 cycles
   localparam int CYCLE_LIMIT = 40 * NUM_PACKETS + RESET_CYCLES;

   logic                 clk;
   logic                 rst_n;
   scan_in_t             scan_in;
   logic [NUM_CAT-1:0]   enable;
   count_t [NUM_CAT-1:0] counts;
   logic [NUM_CAT-1:0]   fired;

   int                   error_count;
   bit                   timed_out;

   integer               seed = 32'h8cc1_43ee;

   // Payload of the packet being sent
   byte_t                pkt_bytes[$];
   // Streams that already had a first packet
   bit                   stream_seen [4];

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #5 clk = ~clk;
      end
   end

   packet_scanner #(
      .PATTERN_A (PAT_A),
      .PAT_LEN_A (PAT_LEN_A),
      .PATTERN_B (PAT_B),
      .PAT_LEN_B (PAT_LEN_B)
   ) uut (
      .clk     (clk),
      .rst_n   (rst_n),
      .scan_in (scan_in),
      .enable  (enable),
      .counts  (counts),
      .fired   (fired)
   );

   scan_checker #(
      .PATTERN_A   (PAT_A),
      .PAT_LEN_A   (PAT_LEN_A),
      .PATTERN_B   (PAT_B),
      .PAT_LEN_B   (PAT_LEN_B),
      .CYCLE_LIMIT (CYCLE_LIMIT)
   ) u_checker (
      .clk         (clk),
      .rst_n       (rst_n),
      .scan_in     (scan_in),
      .enable      (enable),
      .counts      (counts),
      .fired       (fired),
      .error_count (error_count),
      .timed_out   (timed_out)
   );

   function automatic int rand_below(input int n);
      int unsigned r;
      r = $random(seed);
      return int'(r % n);
   endfunction

   // Mostly letters of both patterns, so partial hits are common
   function automatic byte_t draw_byte();
      case (rand_below(10))
         0: return "y";
         1: return "a";
         2: return "h";
         3: return "o";
         4: return "m";
         5: return "a";
         6: return "i";
         7: return "l";
         8: return "y";
         default: return byte_t'(rand_below(256));
      endcase
   endfunction

   // One cycle with no strobe and no byte
   task automatic idle_cycle();
      @(negedge clk);
      scan_in.char_vld   = 1'b0;
      scan_in.load_state = 1'b0;
      scan_in.new_stream = 1'b0;
      scan_in.eop        = 1'b0;
   endtask

   // Load, gap, bytes with random gaps, two idle cycles, eop, gap
   task automatic send_packet(input int sid, input bit new_str, input logic [NUM_CAT-1:0] en);
      @(negedge clk);
      scan_in.stream_id  = stream_id_t'(sid);
      scan_in.load_state = 1'b1;
      scan_in.new_stream = new_str;
      enable             = en;
      idle_cycle();
      foreach (pkt_bytes[i])
      begin
         if (rand_below(5) == 0)
         begin
            idle_cycle();
         end
         @(negedge clk);
         scan_in.char_in  = pkt_bytes[i];
         scan_in.char_vld = 1'b1;
      end
      idle_cycle();
      idle_cycle();
      @(negedge clk);
      scan_in.eop = 1'b1;
      idle_cycle();
      stream_seen[sid] = 1'b1;
   endtask

   task automatic send_text(input int sid, input bit new_str, input logic [NUM_CAT-1:0] en,
                            input string text);
      pkt_bytes.delete();
      for (int i = 0; i < text.len(); i++)
      begin
         pkt_bytes.push_back(text[i]);
      end
      send_packet(sid, new_str, en);
   endtask

   task automatic send_random_packet();
      int                 sid;
      int                 len;
      bit                 new_str;
      logic [NUM_CAT-1:0] en;
      sid     = rand_below(4);
      // First packet of a stream starts fresh, later ones now and then
      new_str = !stream_seen[sid] || (rand_below(8) == 0);
      for (int c = 0; c < NUM_CAT; c++)
      begin
         en[c] = (rand_below(4) != 0);
      end
      len = 1 + rand_below(12);
      pkt_bytes.delete();
      repeat (len)
      begin
         pkt_bytes.push_back(draw_byte());
      end
      send_packet(sid, new_str, en);
   endtask

   task automatic finish_run(input bit timeout);
      int assert_count;
      assert_count = uut.u_assert.fail_count;
      $display("closing: %0d mismatches, %0d assertion failures, timeout %0d",
               error_count, assert_count, timeout);
      if (!timeout && error_count == 0 && assert_count == 0)
      begin
         $display("No errors");
      end
      else
      begin
         $display("Errors found");
      end
      $finish;
   endtask

   initial
   begin
      rst_n   = 1'b0;
      scan_in = '0;
      enable  = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // Pattern twice inside one packet counts once
      send_text(0, 1'b1, 2'b11, "xyahooyahoo");
      // Split across packets of one stream
      send_text(1, 1'b1, 2'b11, "yah");
      send_text(1, 1'b0, 2'b11, "oomail");
      // Fresh stream drops the saved prefix
      send_text(2, 1'b1, 2'b11, "ma");
      send_text(2, 1'b1, 2'b11, "il");
      // Disabled packet with a hit in the middle
      // the next packet resumes from the older save
      send_text(3, 1'b1, 2'b11, "ya");
      send_text(3, 1'b0, 2'b00, "hmail");
      send_text(3, 1'b0, 2'b11, "hoo");
      // Interleaved streams with repeated leading bytes
      send_text(0, 1'b1, 2'b11, "yyah");
      send_text(1, 1'b1, 2'b11, "mmai");
      send_text(0, 1'b0, 2'b11, "oo");
      send_text(1, 1'b0, 2'b11, "l");
      repeat (NUM_RANDOM)
      begin
         send_random_packet();
      end
      repeat (3) @(negedge clk);
      finish_run(1'b0);
   end

   initial
   begin
      @(posedge timed_out);
      finish_run(1'b1);
   end

endmodule

/* tb.f */
design/scan_pkg.sv
design/prefix_matcher.sv
design/category_counter.sv
design/packet_scanner.sv
verif/scan_checker.sv
verif/scan_assert.sv
verif/tb_top.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass message in the run log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim > build.log 2>&1 \
   && ./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 \
   || echo "build or simulation ended with an error status"
touch sim.log
cat sim.log
grep -q "^No errors$" sim.log && echo "PASS" && exit 0 \
   || { echo "FAIL"; exit 1; }
